// ==== sources.f ====
+incdir+src
src/hist_pkg.sv
src/hist_frame_ctrl.sv
src/hist_line_window.sv
src/hist_accum.sv
src/hist_bin_ram.sv
src/hist_readout.sv
src/sens_histogram.sv
verif/tb_sens_histogram.sv

// ==== Makefile ====
# Verilator build and run of the histogram testbench, from the project root
TOP := tb_sens_histogram

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== verif/hist_stimulus.txt ====
# left top width_m1 height_m1 lines pixels enable mode const_hex total_c0 total_c1 total_c2 total_c3
# mode 0 random, 1 constant, 2 ramp; color index is {line parity, pixel parity}
3  2  8  4  9  16 1 0 00 12  15  8   10
0  0  4  3  4  6  1 1 5a 6   4   6   4
10 1  20 2  5  16 1 2 00 3   3   6   6
0  0  7  3  6  8  0 0 00 0   0   0   0
0  0  30 14 16 32 1 0 00 128 120 112 105
1  3  0  0  5  4  1 1 ff 0   0   0   1
2  0  11 6  8  40 1 2 00 24  24  18  18

// ==== verif/tb_sens_histogram.sv ====
// run from the project root so verif/hist_stimulus.txt is found; stops at the first error
`include "hist_consts.svh"

module tb_sens_histogram import hist_pkg::*; ();

    localparam int MAX_FRAMES = 16;
    localparam int C_LEFT     = 0;  // stimulus file columns
    localparam int C_TOP      = 1;
    localparam int C_WM1      = 2;
    localparam int C_HM1      = 3;
    localparam int C_LINES    = 4;
    localparam int C_PIXELS   = 5;
    localparam int C_EN       = 6;
    localparam int C_MODE     = 7;  // 0 random, 1 constant, 2 ramp
    localparam int C_CONST    = 8;
    localparam int C_EXP      = 9;  // four per-color totals follow

    logic   pclk;
    logic   hist_rst_pclk;
    logic   sof_i;
    logic   hact_i;
    pix_t   pix_i;
    logic   set_window_i;
    coord_t left_i;
    coord_t top_i;
    coord_t width_m1_i;
    coord_t height_m1_i;
    logic   hist_en_i;
    logic   hist_rq_o;
    logic   hist_grant_i;
    count_t hist_do_o;
    logic   hist_dv_o;

    int          fr [MAX_FRAMES][13];
    int          n_frames;
    int unsigned model [`HIST_BINS];     // expected bins of the current frame
    count_t      rd_words [`HIST_BINS];
    int          rd_count = 0;
    int          words_left = 0;         // words still owed by accepted grants
    logic        dv_prev = 1'b0;
    int          cycles = 0;
    int          cycle_limit = 0;
    integer      seed;

    sens_histogram sens_histogram_i (.*);

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch at %0t: %s = %0d, expected %0d",
                               $time, name, got, expected));
        end
    endtask

    function automatic bit in_window(input int f, input int x, input int y);
        return (x >= fr[f][C_LEFT]) && (x <= fr[f][C_LEFT] + fr[f][C_WM1]) &&
               (y >= fr[f][C_TOP]) && (y <= fr[f][C_TOP] + fr[f][C_HM1]);
    endfunction

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            fail_run("timeout: the frames and readouts did not finish in time");
        end
    end

    // collects readout words and polices the burst shape
    always @(negedge pclk) begin
        if (hist_dv_o) begin
            if (words_left == 0) begin
                fail_run("hist_dv_o went high without an accepted grant");
            end
            if (hist_rq_o && words_left > 1) begin
                fail_run("hist_rq_o went high while a burst was running");  // may rise with last word
            end
            if (!dv_prev && words_left != `HIST_BURST_LEN) begin
                fail_run("hist_dv_o restarted inside a burst");
            end
            rd_words[rd_count] = hist_do_o;
            rd_count = rd_count + 1;
            words_left = words_left - 1;
        end else if (dv_prev && words_left != 0) begin
            fail_run("hist_dv_o dropped before 256 words were delivered");
        end
        dv_prev = hist_dv_o;
    end

    task automatic drive_frame(input int f);
        int     x;
        int     y;
        pix_t   p;
        color_t c;
        @(posedge pclk);
        left_i       <= coord_t'(fr[f][C_LEFT]);
        top_i        <= coord_t'(fr[f][C_TOP]);
        width_m1_i   <= coord_t'(fr[f][C_WM1]);
        height_m1_i  <= coord_t'(fr[f][C_HM1]);
        set_window_i <= 1'b1;
        hist_en_i    <= (fr[f][C_EN] != 0);
        @(posedge pclk);
        set_window_i <= 1'b0;
        sof_i        <= 1'b1;
        @(posedge pclk);
        sof_i <= 1'b0;
        repeat (3) @(posedge pclk);
        for (y = 0; y < fr[f][C_LINES]; y++) begin
            for (x = 0; x < fr[f][C_PIXELS]; x++) begin
                case (fr[f][C_MODE])
                    0:       p = pix_t'($random(seed));
                    1:       p = pix_t'(fr[f][C_CONST]);
                    default: p = pix_t'((x >> 2) + y);  // same-color repeats 2 pixels apart
                endcase
                c = {y[0], x[0]};  // Bayer color from sensor line and pixel
                if (fr[f][C_EN] != 0 && in_window(f, x, y)) begin
                    model[{c, p}] += 1;
                end
                hact_i <= 1'b1;
                pix_i  <= p;
                @(posedge pclk);
            end
            hact_i <= 1'b0;
            repeat (6) @(posedge pclk);
        end
    endtask

    task automatic read_histogram(input int f);
        int     b;
        int     i;
        count_t sums [4];
        for (i = 0; i < 4; i++) begin
            sums[i] = '0;
        end
        rd_count = 0;
        for (b = 0; b < 4; b++) begin
            @(negedge pclk);
            while (!hist_rq_o) @(negedge pclk);
            @(posedge pclk);
            hist_grant_i <= 1'b1;
            words_left = words_left + `HIST_BURST_LEN;
            @(posedge pclk);
            hist_grant_i <= 1'b0;
            while (words_left != 0) @(negedge pclk);
        end
        repeat (4) begin
            @(negedge pclk);
            check_value("hist_rq_o after the last burst", 32'(hist_rq_o), 0);
        end
        check_value("words read", rd_count, `HIST_BINS);
        for (i = 0; i < `HIST_BINS; i++) begin
            check_value($sformatf("hist_do_o of bin %0d", i), rd_words[i], model[i]);
            sums[i / `HIST_BURST_LEN] += rd_words[i];
            model[i] = 0;  // bins were cleared by the readout
        end
        for (i = 0; i < 4; i++) begin
            check_value($sformatf("color %0d total of frame %0d", i, f), sums[i],
                        fr[f][C_EXP + i]);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    f;
        int    budget;
        string line;
        seed          = 68;
        hist_rst_pclk = 1'b1;
        sof_i         = 1'b0;
        hact_i        = 1'b0;
        pix_i         = '0;
        set_window_i  = 1'b0;
        left_i        = '0;
        top_i         = '0;
        width_m1_i    = '0;
        height_m1_i   = '0;
        hist_en_i     = 1'b0;
        hist_grant_i  = 1'b0;
        n_frames      = 0;
        fd = $fopen("verif/hist_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the stimulus file verif/hist_stimulus.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                if (n_frames == MAX_FRAMES) begin
                    fail_run("the stimulus file holds too many frames");
                end
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %h %d %d %d %d",
                            fr[n_frames][0], fr[n_frames][1], fr[n_frames][2],
                            fr[n_frames][3], fr[n_frames][4], fr[n_frames][5],
                            fr[n_frames][6], fr[n_frames][7], fr[n_frames][8],
                            fr[n_frames][9], fr[n_frames][10], fr[n_frames][11],
                            fr[n_frames][12]);
                if (n == 13) begin
                    n_frames++;
                end else if (n > 0) begin
                    fail_run("a line of the stimulus file has the wrong number of fields");
                end
            end
        end
        $fclose(fd);
        budget = 0;
        for (f = 0; f < n_frames; f++) begin
            budget += fr[f][C_LINES] * (fr[f][C_PIXELS] + 8) + 1400;
        end
        cycle_limit = 2 * budget;

        repeat (3) @(posedge pclk);
        hist_rst_pclk <= 1'b0;
        for (f = 0; f < n_frames; f++) begin
            drive_frame(f);
            if (fr[f][C_EN] != 0) begin
                read_histogram(f);
            end else begin
                repeat (20) begin
                    @(negedge pclk);
                    check_value("hist_rq_o of a disabled frame", 32'(hist_rq_o), 0);
                end
            end
        end

        if (n_frames == 0) begin
            fail_run("the stimulus file holds no frames");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== src/sens_histogram.sv ====
// single pclk domain; the next window waits until the previous histogram is read out
module sens_histogram import hist_pkg::*; (
    input  logic   pclk,
    input  logic   hist_rst_pclk,
    input  logic   sof_i,
    input  logic   hact_i,
    input  pix_t   pix_i,
    input  logic   set_window_i,
    input  coord_t left_i,
    input  coord_t top_i,
    input  coord_t width_m1_i,
    input  coord_t height_m1_i,
    input  logic   hist_en_i,
    output logic   hist_rq_o,
    input  logic   hist_grant_i,
    output count_t hist_do_o,
    output logic   hist_dv_o
);
    logic      vert_woi;
    logic      wait_readout;
    logic      hist_done;
    logic      hist_xfer_done;
    logic      hor_woi;
    bin_addr_t pix_addr;
    bin_addr_t rd_addr;
    count_t    rd_data;
    logic      wr_en;
    bin_addr_t wr_addr;
    count_t    wr_data;
    logic      ram_re;
    bin_addr_t ram_addr;
    count_t    ram_data;

    hist_frame_ctrl hist_frame_ctrl_i (
        .pclk             (pclk),
        .hist_rst_pclk    (hist_rst_pclk),
        .hist_en_i        (hist_en_i),
        .sof_i            (sof_i),
        .hact_i           (hact_i),
        .set_window_i     (set_window_i),
        .top_i            (top_i),
        .height_m1_i      (height_m1_i),
        .hist_xfer_done_i (hist_xfer_done),
        .en_o             (),               // status only
        .vert_woi_o       (vert_woi),
        .wait_readout_o   (wait_readout),
        .hist_done_o      (hist_done)
    );

    hist_line_window hist_line_window_i (
        .pclk           (pclk),
        .hist_rst_pclk  (hist_rst_pclk),
        .sof_i          (sof_i),
        .hact_i         (hact_i),
        .pix_i          (pix_i),
        .set_window_i   (set_window_i),
        .left_i         (left_i),
        .width_m1_i     (width_m1_i),
        .vert_woi_i     (vert_woi),
        .wait_readout_i (wait_readout),
        .hor_woi_o      (hor_woi),
        .pix_addr_o     (pix_addr)
    );

    hist_accum hist_accum_i (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .hor_woi_i     (hor_woi),
        .pix_addr_i    (pix_addr),
        .rd_data_i     (rd_data),
        .rd_addr_o     (rd_addr),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_data_o     (wr_data)
    );

    hist_bin_ram hist_bin_ram_i (
        .pclk        (pclk),
        .a_rd_addr_i (rd_addr),
        .a_rd_data_o (rd_data),
        .a_wr_en_i   (wr_en),
        .a_wr_addr_i (wr_addr),
        .a_wr_data_i (wr_data),
        .b_re_i      (ram_re),
        .b_addr_i    (ram_addr),
        .b_data_o    (ram_data)
    );

    hist_readout hist_readout_i (
        .pclk             (pclk),
        .hist_rst_pclk    (hist_rst_pclk),
        .hist_done_i      (hist_done),
        .hist_grant_i     (hist_grant_i),
        .ram_data_i       (ram_data),
        .ram_re_o         (ram_re),
        .ram_addr_o       (ram_addr),
        .hist_rq_o        (hist_rq_o),
        .hist_do_o        (hist_do_o),
        .hist_dv_o        (hist_dv_o),
        .hist_xfer_done_o (hist_xfer_done)
    );

endmodule

// ==== src/hist_readout.sv ====
// no buffering; bins are cleared as read, so an unfinished readout loses nothing
`include "hist_consts.svh"

module hist_readout import hist_pkg::*; (
    input  logic      pclk,
    input  logic      hist_rst_pclk,
    input  logic      hist_done_i,
    input  logic      hist_grant_i,
    input  count_t    ram_data_i,
    output logic      ram_re_o,
    output bin_addr_t ram_addr_o,
    output logic      hist_rq_o,
    output count_t    hist_do_o,
    output logic      hist_dv_o,
    output logic      hist_xfer_done_o
);
    localparam bin_addr_t BURST_MASK = bin_addr_t'(`HIST_BURST_LEN - 1);
    localparam bin_addr_t LAST_BIN   = bin_addr_t'(`HIST_BINS - 1);

    logic      pend;       // histogram not fully read yet
    logic      re_d;
    bin_addr_t raddr;
    logic      accept;
    logic      burst_end;
    logic      last_bin;

    assign accept     = hist_grant_i && hist_rq_o;  // stray grants ignored
    assign burst_end  = ram_re_o && ((raddr & BURST_MASK) == BURST_MASK);
    assign last_bin   = burst_end && (raddr == LAST_BIN);
    assign ram_addr_o = raddr;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            pend             <= 1'b0;
            hist_rq_o        <= 1'b0;
            ram_re_o         <= 1'b0;
            raddr            <= '0;
            re_d             <= 1'b0;
            hist_dv_o        <= 1'b0;
            hist_xfer_done_o <= 1'b0;
        end else begin
            if (hist_done_i) begin
                pend <= 1'b1;
            end else if (last_bin) begin
                pend <= 1'b0;
            end

            if (accept) begin
                hist_rq_o <= 1'b0;
            end else if (hist_done_i || (pend && !ram_re_o)) begin
                hist_rq_o <= 1'b1;  // first and each following burst
            end

            if (accept) begin
                ram_re_o <= 1'b1;
            end else if (burst_end) begin
                ram_re_o <= 1'b0;
            end

            if (ram_re_o) begin
                raddr <= raddr + 1'b1;  // wraps to 0 for the next frame
            end

            re_d             <= ram_re_o;  // RAM latency
            hist_dv_o        <= re_d;      // output register
            hist_xfer_done_o <= last_bin;
        end
    end

    always_ff @(posedge pclk) begin
        hist_do_o <= ram_data_i;
    end

endmodule

// ==== src/hist_bin_ram.sv ====
// no reset, contents start at zero only through the initial load
`include "hist_consts.svh"

module hist_bin_ram import hist_pkg::*; (
    input  logic      pclk,
    input  bin_addr_t a_rd_addr_i,
    output count_t    a_rd_data_o,
    input  logic      a_wr_en_i,
    input  bin_addr_t a_wr_addr_i,
    input  count_t    a_wr_data_i,
    input  logic      b_re_i,
    input  bin_addr_t b_addr_i,
    output count_t    b_data_o
);
    count_t mem [`HIST_BINS];

    initial begin
        for (int i = 0; i < `HIST_BINS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge pclk) begin
        a_rd_data_o <= mem[a_rd_addr_i];  // read-first
        if (a_wr_en_i) begin
            mem[a_wr_addr_i] <= a_wr_data_i;
        end
        if (b_re_i) begin
            b_data_o       <= mem[b_addr_i];
            mem[b_addr_i]  <= '0;  // clear on read
        end
    end

    // accumulation and readout share the array, frame control keeps them apart
    assert property (@(posedge pclk) (a_wr_en_i !== 1'b1) || (b_re_i !== 1'b1))
        else $error("accumulate write during readout");

endmodule

// ==== src/hist_accum.sv ====
// one pixel per cycle at most; RAM port A must be read-first with 1 cycle latency
module hist_accum import hist_pkg::*; (
    input  logic      pclk,
    input  logic      hist_rst_pclk,
    input  logic      hor_woi_i,
    input  bin_addr_t pix_addr_i,
    input  count_t    rd_data_i,
    output bin_addr_t rd_addr_o,
    output logic      wr_en_o,
    output bin_addr_t wr_addr_o,
    output count_t    wr_data_o
);
    logic      v1;         // read issued
    logic      v2;         // RAM data arriving
    bin_addr_t a2;
    logic      wr_en_d;    // write from the previous cycle, missed by read-first
    bin_addr_t wr_addr_d;
    count_t    wr_data_d;
    count_t    base;

    // newest write wins, the RAM only holds writes older than two cycles
    always_comb begin
        if (wr_en_o && (wr_addr_o == a2)) begin
            base = wr_data_o;
        end else if (wr_en_d && (wr_addr_d == a2)) begin
            base = wr_data_d;
        end else begin
            base = rd_data_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            v1      <= 1'b0;
            v2      <= 1'b0;
            wr_en_o <= 1'b0;
            wr_en_d <= 1'b0;
        end else begin
            v1      <= hor_woi_i;
            v2      <= v1;
            wr_en_o <= v2;
            wr_en_d <= wr_en_o;
        end
    end

    always_ff @(posedge pclk) begin
        rd_addr_o <= pix_addr_i;
        a2        <= rd_addr_o;
        wr_addr_o <= a2;
        wr_data_o <= base + 1'b1;
        wr_addr_d <= wr_addr_o;
        wr_data_d <= wr_data_o;
    end

    assert property (@(posedge pclk) disable iff (hist_rst_pclk)
                     hor_woi_i |-> ##3 wr_en_o)
        else $error("captured pixel not written 3 cycles later");

endmodule

// ==== src/hist_line_window.sv ====
// window is clipped at line end; Bayer parities count sensor pixels, not window pixels
module hist_line_window import hist_pkg::*; (
    input  logic      pclk,
    input  logic      hist_rst_pclk,
    input  logic      sof_i,
    input  logic      hact_i,
    input  pix_t      pix_i,
    input  logic      set_window_i,
    input  coord_t    left_i,
    input  coord_t    width_m1_i,
    input  logic      vert_woi_i,
    input  logic      wait_readout_i,
    output logic      hor_woi_o,
    output bin_addr_t pix_addr_o
);
    coord_t left;
    coord_t width_m1;
    coord_t hcntr;        // left margin, then remaining window pixels
    logic   in_margin;
    logic   in_width;
    logic   hact_d;
    logic   line_par;
    logic   pix_par;
    logic   pix_in_win;
    color_t color;

    assign pix_in_win = (in_margin && (hcntr == '0)) || in_width;
    assign color      = {line_par, pix_par};

    always_ff @(posedge pclk) begin
        if (set_window_i) begin
            left     <= left_i;
            width_m1 <= width_m1_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d    <= 1'b0;
            line_par  <= 1'b0;
            pix_par   <= 1'b0;
            in_margin <= 1'b0;
            in_width  <= 1'b0;
            hcntr     <= '0;
            hor_woi_o <= 1'b0;
        end else begin
            hact_d  <= hact_i;
            pix_par <= hact_i && !pix_par;  // restarts at 0 every line

            if (sof_i) begin
                line_par <= 1'b0;
            end else if (hact_d && !hact_i) begin
                line_par <= !line_par;
            end

            if (!hact_i) begin
                in_margin <= 1'b1;  // reload between lines
                in_width  <= 1'b0;
                hcntr     <= left;
            end else if (in_margin) begin
                if (hcntr == '0) begin
                    in_margin <= 1'b0;  // this pixel is the first in window
                    in_width  <= (width_m1 != '0);
                    hcntr     <= width_m1 - 1'b1;
                end else begin
                    hcntr <= hcntr - 1'b1;
                end
            end else if (in_width) begin
                if (hcntr == '0) begin
                    in_width <= 1'b0;
                end else begin
                    hcntr <= hcntr - 1'b1;
                end
            end

            hor_woi_o <= hact_i && pix_in_win && vert_woi_i && !wait_readout_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (hact_i) begin
            pix_addr_o <= {color, pix_i};
        end
    end

endmodule

// ==== src/hist_frame_ctrl.sv ====
// needs >= 4 idle cycles between lines and >= 2 cycles from sof_i to first line
module hist_frame_ctrl import hist_pkg::*; (
    input  logic   pclk,
    input  logic   hist_rst_pclk,
    input  logic   hist_en_i,
    input  logic   sof_i,
    input  logic   hact_i,
    input  logic   set_window_i,
    input  coord_t top_i,
    input  coord_t height_m1_i,
    input  logic   hist_xfer_done_i,
    output logic   en_o,
    output logic   vert_woi_o,
    output logic   wait_readout_o,
    output logic   hist_done_o
);
    coord_t top;
    coord_t height_m1;
    coord_t vcntr;        // lines left in margin, then in window
    logic   hact_d;
    logic   line_end;
    logic   vcntr_zero;
    logic   top_margin;
    logic   frame_start;

    assign line_end    = hact_d && !hact_i;  // falling edge of hact
    assign vcntr_zero  = (vcntr == '0);
    // frames starting while a readout is pending are skipped entirely
    assign frame_start = sof_i && hist_en_i && !wait_readout_o && !hist_done_o;

    always_ff @(posedge pclk) begin
        if (set_window_i) begin
            top       <= top_i;
            height_m1 <= height_m1_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d         <= 1'b0;
            vcntr          <= '0;
            top_margin     <= 1'b0;
            vert_woi_o     <= 1'b0;
            hist_done_o    <= 1'b0;
            wait_readout_o <= 1'b0;
            en_o           <= 1'b0;
        end else begin
            hact_d      <= hact_i;
            hist_done_o <= vert_woi_o && vcntr_zero && line_end;  // last window line ended

            if (frame_start) begin
                top_margin <= 1'b1;
                vert_woi_o <= 1'b0;
                vcntr      <= top;
            end else if (top_margin && vcntr_zero) begin
                top_margin <= 1'b0;  // next line is the first window line
                vert_woi_o <= 1'b1;
                vcntr      <= height_m1;
            end else if (line_end && (top_margin || vert_woi_o)) begin
                if (vert_woi_o && vcntr_zero) begin
                    vert_woi_o <= 1'b0;
                end else begin
                    vcntr <= vcntr - 1'b1;
                end
            end

            if (hist_done_o) begin
                wait_readout_o <= 1'b1;
            end else if (hist_xfer_done_i) begin
                wait_readout_o <= 1'b0;
            end

            // graceful disable, held through margin, window and readout
            if (sof_i && hist_en_i) begin
                en_o <= 1'b1;
            end else if (!hist_en_i && !top_margin && !vert_woi_o && !hist_done_o &&
                         !wait_readout_o) begin
                en_o <= 1'b0;
            end
        end
    end

    // a second window must not end before the previous histogram is read out
    assert property (@(posedge pclk) disable iff (hist_rst_pclk)
                     hist_done_o |-> !wait_readout_o)
        else $error("hist_done while readout still pending");

endmodule

// ==== src/hist_pkg.sv ====
// plain packed vectors only, all widths come from hist_consts.svh
`include "hist_consts.svh"

package hist_pkg;

    typedef logic [`HIST_PIX_BITS-1:0]   pix_t;       // one sensor pixel
    typedef logic [`HIST_COLOR_BITS-1:0] color_t;     // {line parity, pixel parity}

    // color in the upper bits, so each color owns one contiguous burst
    typedef logic [`HIST_ADDR_BITS-1:0]  bin_addr_t;  // {color, pixel}

    typedef logic [`HIST_COUNT_BITS-1:0] count_t;     // one bin
    typedef logic [`HIST_COORD_BITS-1:0] coord_t;     // coordinate or size minus one

endpackage

// ==== src/hist_consts.svh ====
// sizes are fixed at build time; bins and burst length must stay powers of two
`ifndef HIST_CONSTS_SVH
`define HIST_CONSTS_SVH

// pixel and color fields of the bin address
`define HIST_PIX_BITS   8
`define HIST_COLOR_BITS 2
`define HIST_ADDR_BITS  (`HIST_PIX_BITS + `HIST_COLOR_BITS)

`define HIST_BINS       (1 << `HIST_ADDR_BITS)  // all colors together
`define HIST_BURST_LEN  (1 << `HIST_PIX_BITS)   // one color per burst

`define HIST_COUNT_BITS 32  // no saturation, wraps after 2^32 hits
`define HIST_COORD_BITS 16  // window coordinates and sizes minus one

`endif
